/* hw/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    localparam int ORDER_W = 32;  // commit order width

    typedef logic [31:0]        word_t;       // data word or byte address
    typedef logic [3:0]         byte_mask_t;  // one enable per byte lane
    typedef logic [4:0]         reg_addr_t;   // destination register index
    typedef logic [2:0]         funct3_t;     // access size and signedness
    typedef logic [ORDER_W-1:0] order_t;      // commit sequence number

    // load codes
    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;

    // store codes, same low bits as the loads
    localparam funct3_t F3_SB  = 3'b000;
    localparam funct3_t F3_SH  = 3'b001;
    localparam funct3_t F3_SW  = 3'b010;

endpackage : lsu_pkg

`default_nettype wire

/* hw/lsu_issue_stage.sv */
`default_nettype none

module lsu_issue_stage
    import lsu_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,

    input  wire logic      in_valid_i,
    input  wire logic      in_store_i,
    input  wire funct3_t   in_funct3_i,
    input  wire word_t     in_addr_i,
    input  wire word_t     in_wdata_i,
    input  wire reg_addr_t in_rd_i,
    output logic           in_ready_o,

    output logic           valid_o,
    output logic           store_o,
    output funct3_t        funct3_o,
    output word_t          addr_o,
    output word_t          wdata_o,
    output reg_addr_t      rd_o,
    output order_t         order_o,
    input  wire logic      ready_i
);

    order_t order_cnt;  // tag for the next accepted request
    logic   accept;

    assign in_ready_o = !valid_o || ready_i;  // slot empty or draining
    assign accept     = in_valid_i && in_ready_o;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            valid_o   <= 1'b0;
            order_cnt <= '0;
        end else begin
            if (in_ready_o)
                valid_o <= in_valid_i;
            if (accept)
                order_cnt <= order_cnt + 1'b1;  // one step per request
        end
    end

    // request payload, stamped with the counter value
    always_ff @(posedge clk) begin
        if (accept) begin
            store_o  <= in_store_i;
            funct3_o <= in_funct3_i;
            addr_o   <= in_addr_i;
            wdata_o  <= in_wdata_i;
            rd_o     <= in_rd_i;
            order_o  <= order_cnt;
        end
    end

endmodule : lsu_issue_stage

`default_nettype wire

/* hw/lsu_addr_stage.sv */
`default_nettype none

module lsu_addr_stage
    import lsu_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,

    input  wire logic      valid_i,
    input  wire logic      store_i,
    input  wire funct3_t   funct3_i,
    input  wire word_t     addr_i,
    input  wire word_t     wdata_i,
    input  wire reg_addr_t rd_i,
    input  wire order_t    order_i,
    output logic           ready_o,

    output logic           valid_o,
    output logic           store_o,
    output funct3_t        funct3_o,
    output word_t          word_addr_o,
    output byte_mask_t     mask_o,
    output word_t          wdata_o,
    output reg_addr_t      rd_o,
    output order_t         order_o,
    output logic           err_o,
    input  wire logic      ready_i
);

    logic [1:0] offset;
    logic       bad_code;
    logic       misaligned;
    logic       err_c;
    byte_mask_t mask_c;
    word_t      wdata_c;
    logic       advance;

    assign offset  = addr_i[1:0];
    assign ready_o = !valid_o || ready_i;
    assign advance = valid_i && ready_o;

    always_comb begin
        if (store_i)
            bad_code = !(funct3_i inside {F3_SB, F3_SH, F3_SW});
        else
            bad_code = !(funct3_i inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU});

        // low two bits of funct3 give the size
        case (funct3_i[1:0])
            2'b00: begin
                mask_c     = 4'b0001 << offset;
                misaligned = 1'b0;
            end
            2'b01: begin
                mask_c     = 4'b0011 << offset;
                misaligned = offset[0];  // half must sit on an even byte
            end
            default: begin
                mask_c     = 4'b1111;
                misaligned = offset != 2'b00;
            end
        endcase

        err_c = bad_code || misaligned;
        if (err_c)
            mask_c = 4'b0000;  // no lanes touched on error

        // store data moved onto its byte lanes
        if (store_i)
            wdata_c = wdata_i << {offset, 3'b000};
        else
            wdata_c = wdata_i;
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst)
            valid_o <= 1'b0;
        else if (ready_o)
            valid_o <= valid_i;
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            store_o     <= store_i;
            funct3_o    <= funct3_i;
            word_addr_o <= {addr_i[31:2], 2'b00};  // word aligned
            mask_o      <= mask_c;
            wdata_o     <= wdata_c;
            rd_o        <= rd_i;
            order_o     <= order_i;
            err_o       <= err_c;
        end
    end

endmodule : lsu_addr_stage

`default_nettype wire

/* hw/lsu_mem_stage.sv */
`default_nettype none

module lsu_mem_stage
    import lsu_pkg::*;
#(
    parameter int RAM_WORDS = 256
) (
    input  wire logic       clk,
    input  wire logic       rst,

    input  wire logic       valid_i,
    input  wire logic       store_i,
    input  wire funct3_t    funct3_i,
    input  wire word_t      word_addr_i,
    input  wire byte_mask_t mask_i,
    input  wire word_t      wdata_i,
    input  wire reg_addr_t  rd_i,
    input  wire order_t     order_i,
    input  wire logic       err_i,
    output logic            ready_o,

    output logic            valid_o,
    output logic            store_o,
    output funct3_t         funct3_o,
    output word_t           rdata_o,
    output byte_mask_t      mask_o,
    output reg_addr_t       rd_o,
    output order_t          order_o,
    output logic            err_o,
    input  wire logic       ready_i
);

    localparam int IDX_W = $clog2(RAM_WORDS);

    word_t             ram [RAM_WORDS];
    logic [IDX_W-1:0]  row;      // RAM row for this item
    logic              advance;
    logic              wr_en;

    assign row     = IDX_W'((word_addr_i >> 2) % RAM_WORDS);  // wraps at depth
    assign ready_o = !valid_o || ready_i;
    assign advance = valid_i && ready_o;
    assign wr_en   = advance && store_i && !err_i;

    // byte-enabled write, read returns the row before the write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (mask_i[b])
                    ram[row][8*b +: 8] <= wdata_i[8*b +: 8];
            end
        end
        if (advance)
            rdata_o <= ram[row];
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst)
            valid_o <= 1'b0;
        else if (ready_o)
            valid_o <= valid_i;
    end

    // side fields ride along with the read word
    always_ff @(posedge clk) begin
        if (advance) begin
            store_o  <= store_i;
            funct3_o <= funct3_i;
            mask_o   <= mask_i;
            rd_o     <= rd_i;
            order_o  <= order_i;
            err_o    <= err_i;
        end
    end

endmodule : lsu_mem_stage

`default_nettype wire

/* hw/lsu_load_align_stage.sv */
`default_nettype none

module lsu_load_align_stage
    import lsu_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,

    input  wire logic       valid_i,
    input  wire logic       store_i,
    input  wire funct3_t    funct3_i,
    input  wire word_t      rdata_i,
    input  wire byte_mask_t mask_i,
    input  wire reg_addr_t  rd_i,
    input  wire order_t     order_i,
    input  wire logic       err_i,
    output logic            ready_o,

    output logic            valid_o,
    output word_t           result_o,
    output logic            store_o,
    output reg_addr_t       rd_o,
    output order_t          order_o,
    output logic            err_o,
    input  wire logic       ready_i
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    word_t       result_c;
    logic        advance;

    assign ready_o = !valid_o || ready_i;
    assign advance = valid_i && ready_o;

    // lane picked by the mask from the address stage
    always_comb begin
        byte_sel = rdata_i[7:0];
        half_sel = rdata_i[15:0];
        case (mask_i)
            4'b0010: byte_sel = rdata_i[15:8];
            4'b0100: byte_sel = rdata_i[23:16];
            4'b1000: byte_sel = rdata_i[31:24];
            4'b1100: half_sel = rdata_i[31:16];
            default: ;
        endcase
    end

    always_comb begin
        case (funct3_i)
            F3_LB:   result_c = {{24{byte_sel[7]}}, byte_sel};
            F3_LBU:  result_c = {24'b0, byte_sel};
            F3_LH:   result_c = {{16{half_sel[15]}}, half_sel};
            F3_LHU:  result_c = {16'b0, half_sel};
            default: result_c = rdata_i;  // whole word
        endcase
        if (store_i || err_i)
            result_c = '0;  // nothing to write back
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst)
            valid_o <= 1'b0;
        else if (ready_o)
            valid_o <= valid_i;
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            result_o <= result_c;
            store_o  <= store_i;
            rd_o     <= rd_i;
            order_o  <= order_i;
            err_o    <= err_i;
        end
    end

endmodule : lsu_load_align_stage

`default_nettype wire

/* hw/lsu_pipe.sv */
`default_nettype none

module lsu_pipe
    import lsu_pkg::*;
#(
    parameter int RAM_WORDS = 256
) (
    input  wire logic      clk,
    input  wire logic      rst,

    input  wire logic      in_valid_i,
    output logic           in_ready_o,
    input  wire logic      in_store_i,
    input  wire funct3_t   in_funct3_i,
    input  wire word_t     in_addr_i,
    input  wire word_t     in_wdata_i,
    input  wire reg_addr_t in_rd_i,

    output logic           out_valid_o,
    input  wire logic      out_ready_i,
    output word_t          out_result_o,
    output logic           out_store_o,
    output reg_addr_t      out_rd_o,
    output order_t         out_order_o,
    output logic           out_err_o
);

    // issue -> address
    logic       is_valid, is_ready, is_store;
    funct3_t    is_funct3;
    word_t      is_addr, is_wdata;
    reg_addr_t  is_rd;
    order_t     is_order;

    // address -> memory
    logic       ag_valid, ag_ready, ag_store, ag_err;
    funct3_t    ag_funct3;
    word_t      ag_word_addr, ag_wdata;
    byte_mask_t ag_mask;
    reg_addr_t  ag_rd;
    order_t     ag_order;

    // memory -> align
    logic       mm_valid, mm_ready, mm_store, mm_err;
    funct3_t    mm_funct3;
    word_t      mm_rdata;
    byte_mask_t mm_mask;
    reg_addr_t  mm_rd;
    order_t     mm_order;

    lsu_issue_stage issue_i (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (in_valid_i),
        .in_store_i  (in_store_i),
        .in_funct3_i (in_funct3_i),
        .in_addr_i   (in_addr_i),
        .in_wdata_i  (in_wdata_i),
        .in_rd_i     (in_rd_i),
        .in_ready_o  (in_ready_o),
        .valid_o     (is_valid),
        .store_o     (is_store),
        .funct3_o    (is_funct3),
        .addr_o      (is_addr),
        .wdata_o     (is_wdata),
        .rd_o        (is_rd),
        .order_o     (is_order),
        .ready_i     (is_ready)
    );

    lsu_addr_stage addr_i (
        .clk         (clk),
        .rst         (rst),
        .valid_i     (is_valid),
        .store_i     (is_store),
        .funct3_i    (is_funct3),
        .addr_i      (is_addr),
        .wdata_i     (is_wdata),
        .rd_i        (is_rd),
        .order_i     (is_order),
        .ready_o     (is_ready),
        .valid_o     (ag_valid),
        .store_o     (ag_store),
        .funct3_o    (ag_funct3),
        .word_addr_o (ag_word_addr),
        .mask_o      (ag_mask),
        .wdata_o     (ag_wdata),
        .rd_o        (ag_rd),
        .order_o     (ag_order),
        .err_o       (ag_err),
        .ready_i     (ag_ready)
    );

    lsu_mem_stage #(
        .RAM_WORDS (RAM_WORDS)
    ) mem_i (
        .clk         (clk),
        .rst         (rst),
        .valid_i     (ag_valid),
        .store_i     (ag_store),
        .funct3_i    (ag_funct3),
        .word_addr_i (ag_word_addr),
        .mask_i      (ag_mask),
        .wdata_i     (ag_wdata),
        .rd_i        (ag_rd),
        .order_i     (ag_order),
        .err_i       (ag_err),
        .ready_o     (ag_ready),
        .valid_o     (mm_valid),
        .store_o     (mm_store),
        .funct3_o    (mm_funct3),
        .rdata_o     (mm_rdata),
        .mask_o      (mm_mask),
        .rd_o        (mm_rd),
        .order_o     (mm_order),
        .err_o       (mm_err),
        .ready_i     (mm_ready)
    );

    lsu_load_align_stage align_i (
        .clk         (clk),
        .rst         (rst),
        .valid_i     (mm_valid),
        .store_i     (mm_store),
        .funct3_i    (mm_funct3),
        .rdata_i     (mm_rdata),
        .mask_i      (mm_mask),
        .rd_i        (mm_rd),
        .order_i     (mm_order),
        .err_i       (mm_err),
        .ready_o     (mm_ready),
        .valid_o     (out_valid_o),
        .result_o    (out_result_o),
        .store_o     (out_store_o),
        .rd_o        (out_rd_o),
        .order_o     (out_order_o),
        .err_o       (out_err_o),
        .ready_i     (out_ready_i)
    );

endmodule : lsu_pipe

`default_nettype wire

/* sim/lsu_tb_tasks.svh */
`ifndef LSU_TB_TASKS_SVH
`define LSU_TB_TASKS_SVH

function automatic word_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

task automatic check_word(input string what, input word_t exp, input word_t act);
    check_cnt++;
    if (act !== exp) begin
        err_cnt++;
        $display("FAIL %s %s: expected %08h, actual %08h", cur_test, what, exp, act);
    end
endtask

task automatic check_order(input string what, input order_t exp, input order_t act);
    check_cnt++;
    if (act !== exp) begin
        err_cnt++;
        $display("FAIL %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
    end
endtask

task automatic check_bit(input string what, input logic exp, input logic act);
    check_cnt++;
    if (act !== exp) begin
        err_cnt++;
        $display("FAIL %s %s: expected %b, actual %b", cur_test, what, exp, act);
    end
endtask

// size and alignment rule for one access
function automatic logic access_err(input logic store, input funct3_t f3, input word_t addr);
    logic bad;
    if (store) begin
        case (f3)
            F3_SB:   bad = 1'b0;
            F3_SH:   bad = addr[0];
            F3_SW:   bad = addr[1:0] != 2'b00;
            default: bad = 1'b1;
        endcase
    end else begin
        case (f3)
            F3_LB, F3_LBU: bad = 1'b0;
            F3_LH, F3_LHU: bad = addr[0];
            F3_LW:         bad = addr[1:0] != 2'b00;
            default:       bad = 1'b1;
        endcase
    end
    return bad;
endfunction

// applies one request to the memory model in issue order
task automatic model_access(input logic store, input funct3_t f3, input word_t addr,
                            input word_t wdata, output word_t result, output logic err);
    int    row;
    int    sh;
    word_t cur;
    row    = int'((addr >> 2) % RAM_WORDS);
    sh     = 8 * int'(addr[1:0]);
    err    = access_err(store, f3, addr);
    result = '0;
    cur    = mem_model[row];
    if (!err && store) begin
        case (f3)
            F3_SB:   cur[sh +: 8]  = wdata[7:0];
            F3_SH:   cur[sh +: 16] = wdata[15:0];
            default: cur           = wdata;
        endcase
        mem_model[row] = cur;
    end else if (!err) begin
        case (f3)
            F3_LB:   result = {{24{cur[sh + 7]}}, cur[sh +: 8]};
            F3_LBU:  result = {24'b0, cur[sh +: 8]};
            F3_LH:   result = {{16{cur[sh + 15]}}, cur[sh +: 16]};
            F3_LHU:  result = {16'b0, cur[sh +: 16]};
            default: result = cur;
        endcase
    end
endtask

// called just after a rising edge, returns on the edge that takes the request
task automatic send_request(input logic store, input funct3_t f3, input word_t addr,
                            input word_t wdata, input reg_addr_t rd);
    word_t result;
    logic  err;
    model_access(store, f3, addr, wdata, result, err);
    exp_result.push_back(result);
    exp_store.push_back(store);
    exp_err.push_back(err);
    exp_rd.push_back(rd);
    exp_order.push_back(issue_cnt);
    issue_cnt++;
    in_valid  <= 1'b1;
    in_store  <= store;
    in_funct3 <= f3;
    in_addr   <= addr;
    in_wdata  <= wdata;
    in_rd     <= rd;
    @(negedge clk);
    while (!in_ready)
        @(negedge clk);
    @(posedge clk);
endtask

task automatic drain_and_compare(input logic check_lat);
    int lat;
    in_valid <= 1'b0;
    while (obs_result.size() < exp_result.size())
        @(posedge clk);
    repeat (6) @(posedge clk);  // a duplicate would show up by now
    if (obs_result.size() != exp_result.size()) begin
        err_cnt++;
        $display("%s: %0d results came out for %0d requests",
                 cur_test, obs_result.size(), exp_result.size());
    end
    while (exp_result.size() > 0 && obs_result.size() > 0) begin
        check_word("result", exp_result.pop_front(), obs_result.pop_front());
        check_bit("store", exp_store.pop_front(), obs_store.pop_front());
        check_bit("err", exp_err.pop_front(), obs_err.pop_front());
        check_word("rd", word_t'(exp_rd.pop_front()), word_t'(obs_rd.pop_front()));
        check_order("order", exp_order.pop_front(), obs_order.pop_front());
        lat = out_cycle.pop_front() - acc_cycle.pop_front();
        if (check_lat && lat != 4) begin
            err_cnt++;
            $display("FAIL %s latency: expected 4, actual %0d", cur_test, lat);
        end
    end
    exp_result.delete();
    exp_store.delete();
    exp_err.delete();
    exp_rd.delete();
    exp_order.delete();
    obs_result.delete();
    obs_store.delete();
    obs_err.delete();
    obs_rd.delete();
    obs_order.delete();
    acc_cycle.delete();
    out_cycle.delete();
endtask

task automatic start_test(input string name);
    cur_test       = name;
    test_err_start = err_cnt;
endtask

task automatic finish_test();
    test_cnt++;
    if (err_cnt == test_err_start) begin
        $display("%s: ok", cur_test);
    end else begin
        failed_tests++;
        $display("%s: %0d errors", cur_test, err_cnt - test_err_start);
    end
endtask

task automatic word_store_load();
    start_test("word_store_load");
    for (int i = 0; i < RAM_WORDS; i++)
        send_request(1'b1, F3_SW, word_t'(i) << 2, lcg_next(), reg_addr_t'(i));
    // read back through the aliased upper addresses
    for (int i = 0; i < RAM_WORDS; i++)
        send_request(1'b0, F3_LW, word_t'(i + RAM_WORDS) << 2, 32'h0, reg_addr_t'(i + 3));
    drain_and_compare(1'b1);
    finish_test();
endtask

task automatic sub_word_loads();
    word_t pats [4] = '{32'h80ff7f01, 32'h7f80ff00, 32'hdeadbeef, 32'h01234567};
    word_t base;
    start_test("sub_word_loads");
    for (int w = 0; w < 4; w++) begin
        base = 32'h0000_0100 + word_t'(4 * w);
        send_request(1'b1, F3_SW, base, pats[w], 5'd0);
        for (int b = 0; b < 4; b++) begin
            send_request(1'b0, F3_LB, base + word_t'(b), 32'h0, reg_addr_t'(b + 1));
            send_request(1'b0, F3_LBU, base + word_t'(b), 32'h0, reg_addr_t'(b + 5));
        end
        for (int h = 0; h < 4; h += 2) begin
            send_request(1'b0, F3_LH, base + word_t'(h), 32'h0, reg_addr_t'(h + 10));
            send_request(1'b0, F3_LHU, base + word_t'(h), 32'h0, reg_addr_t'(h + 20));
        end
    end
    drain_and_compare(1'b1);
    finish_test();
endtask

task automatic partial_stores();
    word_t base;
    start_test("partial_stores");
    for (int n = 0; n < 6; n++) begin
        base = lcg_next() & 32'hffff_fffc;  // any word, wraps into the RAM
        for (int b = 0; b < 4; b++) begin
            send_request(1'b1, F3_SB, base + word_t'(b), lcg_next(), 5'd1);
            send_request(1'b0, F3_LW, base, 32'h0, 5'd2);
        end
        for (int h = 0; h < 4; h += 2) begin
            send_request(1'b1, F3_SH, base + word_t'(h), lcg_next(), 5'd3);
            send_request(1'b0, F3_LW, base, 32'h0, 5'd4);
        end
    end
    drain_and_compare(1'b1);
    finish_test();
endtask

task automatic access_errors();
    word_t base;
    start_test("access_errors");
    base = 32'h0000_0040;
    send_request(1'b1, F3_SW, base, 32'h1357_9bdf, 5'd1);
    send_request(1'b1, F3_SH, base + 1, 32'hffff_ffff, 5'd2);   // odd half
    send_request(1'b1, F3_SW, base + 2, 32'hffff_ffff, 5'd3);
    send_request(1'b1, 3'b100, base, 32'hffff_ffff, 5'd4);      // no such store
    send_request(1'b0, F3_LH, base + 3, 32'h0, 5'd5);
    send_request(1'b0, F3_LW, base + 1, 32'h0, 5'd6);
    send_request(1'b0, 3'b011, base, 32'h0, 5'd7);
    send_request(1'b0, 3'b111, base, 32'h0, 5'd8);
    send_request(1'b0, F3_LW, base, 32'h0, 5'd9);               // still the first word
    drain_and_compare(1'b1);
    finish_test();
endtask

task automatic order_backpressure();
    word_t addr;
    start_test("order_backpressure");
    ready_mode <= 2'd1;
    for (int i = 0; i < STREAM_LEN; i++) begin
        addr = 32'h0000_0200 + word_t'(4 * ((i / 2) % 32));
        if (i % 2 == 0)
            send_request(1'b1, F3_SW, addr, word_t'(i) * 32'h9e37_79b9, reg_addr_t'(i));
        else
            send_request(1'b0, F3_LW, addr, 32'h0, reg_addr_t'(i));
    end
    drain_and_compare(1'b0);

    // four items fill every stage while the output is held
    ready_mode <= 2'd2;
    for (int i = 0; i < 4; i++)
        send_request(1'b0, F3_LW, 32'h0000_0200 + word_t'(4 * i), 32'h0, reg_addr_t'(i));
    in_valid <= 1'b0;
    repeat (3) begin
        @(negedge clk);
        check_bit("in_ready while full", 1'b0, in_ready);
        check_bit("out_valid while held", 1'b1, out_valid);
    end
    @(posedge clk);
    ready_mode <= 2'd0;
    drain_and_compare(1'b0);
    finish_test();
endtask

`endif

/* sim/lsu_pipe_tb.sv */
`default_nettype none

module lsu_pipe_tb
    import lsu_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    RAM_WORDS    = 256;
    localparam int    RESET_CYCLES = 16;
    localparam int    STREAM_LEN   = 300;
    localparam word_t LCG_SEED     = 32'h59678be4;
    // two passes over the RAM, the stalled stream, and room for the short tests
    localparam int    TIMEOUT_CYCLES = RESET_CYCLES + 2 * RAM_WORDS + 8 * STREAM_LEN + 1000;

    logic      clk;
    logic      rst;
    logic      in_valid;
    logic      in_ready;
    logic      in_store;
    funct3_t   in_funct3;
    word_t     in_addr;
    word_t     in_wdata;
    reg_addr_t in_rd;
    logic      out_valid;
    logic      out_ready = 1'b1;
    word_t     out_result;
    logic      out_store;
    reg_addr_t out_rd;
    order_t    out_order;
    logic      out_err;

    logic [1:0] ready_mode;  // 0 high, 1 random, 2 held low
    int         cycle_cnt;

    word_t     mem_model [RAM_WORDS];
    word_t     lcg_state;
    order_t    issue_cnt;
    string     cur_test;
    int        err_cnt;
    int        check_cnt;
    int        test_cnt;
    int        failed_tests;
    int        test_err_start;

    // expected and observed results, oldest first
    word_t     exp_result[$];
    word_t     obs_result[$];
    logic      exp_store[$];
    logic      obs_store[$];
    logic      exp_err[$];
    logic      obs_err[$];
    reg_addr_t exp_rd[$];
    reg_addr_t obs_rd[$];
    order_t    exp_order[$];
    order_t    obs_order[$];
    int        acc_cycle[$];
    int        out_cycle[$];

    lsu_pipe #(
        .RAM_WORDS (RAM_WORDS)
    ) dut_i (
        .clk          (clk),
        .rst          (rst),
        .in_valid_i   (in_valid),
        .in_ready_o   (in_ready),
        .in_store_i   (in_store),
        .in_funct3_i  (in_funct3),
        .in_addr_i    (in_addr),
        .in_wdata_i   (in_wdata),
        .in_rd_i      (in_rd),
        .out_valid_o  (out_valid),
        .out_ready_i  (out_ready),
        .out_result_o (out_result),
        .out_store_o  (out_store),
        .out_rd_o     (out_rd),
        .out_order_o  (out_order),
        .out_err_o    (out_err)
    );

    `include "lsu_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles in test %s", cycle_cnt, cur_test);
        $display("TEST FAILED");
        $finish;
    end

    // output back-pressure
    always @(posedge clk) begin
        case (ready_mode)
            2'd1:    out_ready <= (lcg_next() >= 32'h6000_0000);
            2'd2:    out_ready <= 1'b0;
            default: out_ready <= 1'b1;
        endcase
    end

    // transfers are decided by values that are stable at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (in_valid && in_ready)
                acc_cycle.push_back(cycle_cnt + 1);  // edge that takes it
            if (out_valid && out_ready) begin
                obs_result.push_back(out_result);
                obs_store.push_back(out_store);
                obs_err.push_back(out_err);
                obs_rd.push_back(out_rd);
                obs_order.push_back(out_order);
                out_cycle.push_back(cycle_cnt + 1);  // edge that delivers it
            end
        end
    end

    initial begin
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_store     = 1'b0;
        in_funct3    = F3_LW;
        in_addr      = '0;
        in_wdata     = '0;
        in_rd        = '0;
        ready_mode   = 2'd0;
        lcg_state    = LCG_SEED;
        issue_cnt    = '0;
        cur_test     = "reset";
        err_cnt      = 0;
        check_cnt    = 0;
        test_cnt     = 0;
        failed_tests = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        word_store_load();
        sub_word_loads();
        partial_stores();
        access_errors();
        order_backpressure();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 test_cnt, failed_tests, check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule : lsu_pipe_tb

`default_nettype wire

/* lsu_pipe.f */
+incdir+sim
hw/lsu_pkg.sv
hw/lsu_issue_stage.sv
hw/lsu_addr_stage.sv
hw/lsu_mem_stage.sv
hw/lsu_load_align_stage.sv
hw/lsu_pipe.sv
sim/lsu_pipe_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the lsu_pipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f lsu_pipe.f --top-module lsu_pipe_tb -o lsu_pipe_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/lsu_pipe_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1
